// ==== Bender.yml ====
package:
  name: coherence_bus

sources:
  - files:
      - src/coherence_pkg.sv
      - src/bus_arbiter.sv
      - src/l2_cache.sv
      - src/bus_response.sv
      - src/coherence_bus_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/coherence_bus_tb.sv

// ==== sim/coherence_bus_tests.svh ====
// Word that the first test fills and the next two reuse
localparam addr_t home_addr = {21'h00A11, 9'h010, 2'b00};

// Cold read misses and the retry finds the filled word
task automatic miss_then_fill();
	resp_t resp;
	word_t data;
	read_word(1, home_addr, resp, data);
	check_resp("miss_fill first read", resp_none, '0, resp, data);
	wait_fill("miss_fill", home_addr);
	read_word(1, home_addr, resp, data);
	check_resp("miss_fill retry", resp_l2, mem_word(home_addr), resp, data);
endtask

// Other core's L1 wins over an L2 hit
task automatic peer_forwarding();
	resp_t resp;
	word_t data;
	@(posedge clk);
	snoop_hit_core2  <= 1'b1;
	snoop_data_core2 <= snoop_word2;
	read_word(1, home_addr, resp, data);
	check_resp("peer_forward core1", resp_peer, snoop_word2, resp, data);
	@(posedge clk);
	snoop_hit_core2  <= 1'b0;
	snoop_hit_core1  <= 1'b1;
	snoop_data_core1 <= snoop_word1;
	read_word(2, home_addr, resp, data);
	check_resp("peer_forward core2", resp_peer, snoop_word1, resp, data);
	@(posedge clk);
	snoop_hit_core1 <= 1'b0;
	// Without a snoop hit the L2 copy comes back
	read_word(2, home_addr, resp, data);
	check_resp("peer_forward no snoop", resp_l2, mem_word(home_addr), resp, data);
endtask

// Both cores hold requests and grants alternate from core 1
task automatic arbitration_alternates();
	int expect_core;
	int last_core;
	int i;
	expect_core = 1;
	last_core = 0;
	@(posedge clk);
	req_core1        <= 1'b1;
	req_core2        <= 1'b1;
	addr_core1       <= home_addr;
	addr_core2       <= home_addr;
	// Distinct snoop words show which core each response went to
	snoop_hit_core1  <= 1'b1;
	snoop_hit_core2  <= 1'b1;
	snoop_data_core1 <= snoop_word1;
	snoop_data_core2 <= snoop_word2;
	for (i = 0; i < 6; i++) begin
		@(negedge clk);
		check_value($sformatf("arbitration grant_core1 cycle %0d", i),
			word_t'(expect_core == 1), word_t'(grant_core1));
		check_value($sformatf("arbitration grant_core2 cycle %0d", i),
			word_t'(expect_core == 2), word_t'(grant_core2));
		if (last_core != 0) begin
			check_value($sformatf("arbitration resp_valid_core1 cycle %0d", i),
				word_t'(last_core == 1), word_t'(resp_valid_core1));
			check_value($sformatf("arbitration resp_valid_core2 cycle %0d", i),
				word_t'(last_core == 2), word_t'(resp_valid_core2));
			if (last_core == 1) begin
				check_resp("arbitration core1", resp_peer, snoop_word2, resp_core1, data_core1);
			end else begin
				check_resp("arbitration core2", resp_peer, snoop_word1, resp_core2, data_core2);
			end
		end
		last_core = expect_core;
		expect_core = 3 - expect_core;
	end
	@(posedge clk);
	req_core1       <= 1'b0;
	req_core2       <= 1'b0;
	snoop_hit_core1 <= 1'b0;
	snoop_hit_core2 <= 1'b0;
	@(negedge clk);
	// Last grant went to core 2
	check_value("arbitration final resp_valid_core2", 32'd1, word_t'(resp_valid_core2));
	check_resp("arbitration final core2", resp_peer, snoop_word1, resp_core2, data_core2);
endtask

// Two tags share a set and a re-flush overwrites in place
task automatic flush_placement();
	addr_t addr_a;
	addr_t addr_b;
	resp_t resp;
	word_t data;
	addr_a = make_addr(21'h00123, 9'h055);
	addr_b = make_addr(21'h00456, 9'h055);
	flush_word(1, addr_a, 32'hA000_0001);
	flush_word(2, addr_b, 32'hB000_0002);
	read_word(2, addr_b, resp, data);
	check_resp("flush_placement tag b", resp_l2, 32'hB000_0002, resp, data);
	// Reading A last leaves B's way as the LRU way
	read_word(1, addr_a, resp, data);
	check_resp("flush_placement tag a", resp_l2, 32'hA000_0001, resp, data);
	flush_word(2, addr_a, 32'hA000_0003);
	read_word(2, addr_a, resp, data);
	check_resp("flush_placement rewrite a", resp_l2, 32'hA000_0003, resp, data);
	read_word(1, addr_b, resp, data);
	check_resp("flush_placement keep b", resp_l2, 32'hB000_0002, resp, data);
endtask

// After A is used again, a flush of C replaces B
task automatic lru_eviction();
	addr_t addr_a;
	addr_t addr_b;
	addr_t addr_c;
	resp_t resp;
	word_t data;
	addr_a = make_addr(21'h0AAAA, 9'h1A3);
	addr_b = make_addr(21'h15555, 9'h1A3);
	addr_c = make_addr(21'h03C3C, 9'h1A3);
	read_word(1, addr_a, resp, data);
	check_resp("lru fill a", resp_none, '0, resp, data);
	wait_fill("lru fill a", addr_a);
	read_word(1, addr_a, resp, data);
	check_resp("lru filled a", resp_l2, mem_word(addr_a), resp, data);
	read_word(2, addr_b, resp, data);
	check_resp("lru fill b", resp_none, '0, resp, data);
	wait_fill("lru fill b", addr_b);
	read_word(2, addr_b, resp, data);
	check_resp("lru filled b", resp_l2, mem_word(addr_b), resp, data);
	read_word(1, addr_a, resp, data);
	check_resp("lru touch a", resp_l2, mem_word(addr_a), resp, data);
	flush_word(1, addr_c, 32'hC000_0005);
	read_word(1, addr_a, resp, data);
	check_resp("lru keep a", resp_l2, mem_word(addr_a), resp, data);
	read_word(2, addr_c, resp, data);
	check_resp("lru flushed c", resp_l2, 32'hC000_0005, resp, data);
	read_word(2, addr_b, resp, data);
	check_resp("lru evicted b", resp_none, '0, resp, data);
	wait_fill("lru refetch b", addr_b);
endtask

// ==== sim/coherence_bus_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module coherence_bus_tb import coherence_pkg::*; ();

	// Bounds on every wait, in cycles
	localparam int grant_limit = 20;
	localparam int fill_limit  = 40;
	// Memory answers with the address scrambled by this word
	localparam word_t mem_pattern = 32'hC0DE_5EED;
	// Snoop words that each core's L1 returns
	localparam word_t snoop_word1 = 32'h1111_C001;
	localparam word_t snoop_word2 = 32'h2222_C002;

	logic  clk;
	logic  reset;
	logic  req_core1;
	addr_t addr_core1;
	logic  snoop_hit_core1;
	word_t snoop_data_core1;
	logic  flush_core1;
	addr_t flush_addr_core1;
	word_t flush_data_core1;
	logic  grant_core1;
	logic  resp_valid_core1;
	resp_t resp_core1;
	word_t data_core1;
	logic  req_core2;
	addr_t addr_core2;
	logic  snoop_hit_core2;
	word_t snoop_data_core2;
	logic  flush_core2;
	addr_t flush_addr_core2;
	word_t flush_data_core2;
	logic  grant_core2;
	logic  resp_valid_core2;
	resp_t resp_core2;
	word_t data_core2;
	logic  dmem_read;
	addr_t dmem_addr;
	// Driven only by the memory model
	logic  dmem_valid = 1'b0;
	word_t dmem_data  = '0;

	int check_count = 0;
	int error_count = 0;

	// Memory model state
	logic [15:0] lfsr_state = 16'd7792;
	logic        mem_busy;
	logic [2:0]  mem_wait;
	logic [2:0]  mem_delay;

	coherence_bus_top DUT (
		.clk              (clk),
		.reset            (reset),
		.req_core1        (req_core1),
		.addr_core1       (addr_core1),
		.snoop_hit_core1  (snoop_hit_core1),
		.snoop_data_core1 (snoop_data_core1),
		.flush_core1      (flush_core1),
		.flush_addr_core1 (flush_addr_core1),
		.flush_data_core1 (flush_data_core1),
		.grant_core1      (grant_core1),
		.resp_valid_core1 (resp_valid_core1),
		.resp_core1       (resp_core1),
		.data_core1       (data_core1),
		.req_core2        (req_core2),
		.addr_core2       (addr_core2),
		.snoop_hit_core2  (snoop_hit_core2),
		.snoop_data_core2 (snoop_data_core2),
		.flush_core2      (flush_core2),
		.flush_addr_core2 (flush_addr_core2),
		.flush_data_core2 (flush_data_core2),
		.grant_core2      (grant_core2),
		.resp_valid_core2 (resp_valid_core2),
		.resp_core2       (resp_core2),
		.data_core2       (data_core2),
		.dmem_read        (dmem_read),
		.dmem_addr        (dmem_addr),
		.dmem_valid       (dmem_valid),
		.dmem_data        (dmem_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = !clk;
	end

	// Galois LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 16'hB400;
		end
		return state >> 1;
	endfunction

	// Word the memory holds at an address
	function automatic word_t mem_word(input addr_t addr);
		return addr ^ mem_pattern;
	endfunction

	// Byte address of a word from tag and set index
	function automatic addr_t make_addr(input tag_t tag, input index_t index);
		return {tag, index, 2'b00};
	endfunction

	function automatic logic is_granted(input int core);
		return (core == 1) ? grant_core1 : grant_core2;
	endfunction

	function automatic logic has_response(input int core);
		return (core == 1) ? resp_valid_core1 : resp_valid_core2;
	endfunction

	// Data memory gives one reply per dmem_read after 1 to 4 cycles
	always @(posedge clk) begin
		if (reset) begin
			mem_busy   <= 1'b0;
			mem_wait   <= '0;
			dmem_valid <= 1'b0;
			dmem_data  <= '0;
		end else begin
			dmem_valid <= 1'b0;
			// dmem_read is still high in the cycle of the reply
			if (dmem_read && !mem_busy && !dmem_valid) begin
				// One LFSR step per delay bit
				mem_delay = 3'd1 + {2'b00, lfsr_state[0]};
				lfsr_state = lfsr_step(lfsr_state);
				mem_delay = mem_delay + {1'b0, lfsr_state[0], 1'b0};
				lfsr_state = lfsr_step(lfsr_state);
				mem_busy <= 1'b1;
				mem_wait <= mem_delay;
			end else if (mem_busy) begin
				if (mem_wait == 3'd1) begin
					mem_busy   <= 1'b0;
					dmem_valid <= 1'b1;
					dmem_data  <= mem_word(dmem_addr);
				end else begin
					mem_wait <= mem_wait - 3'd1;
				end
			end
		end
	end

	// Ends the run after a wait that never completed
	task automatic abort_run(input string why);
		error_count++;
		$display("%s", why);
		$display("checks %0d, errors %0d", check_count, error_count);
		$display("STATUS: FAIL");
		$finish;
	endtask

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_resp(input string name, input resp_t exp_resp, input word_t exp_data,
			input resp_t resp, input word_t data);
		check_value({name, " code"}, word_t'(exp_resp), word_t'(resp));
		check_value({name, " data"}, exp_data, data);
	endtask

	// Request a read and take the response one cycle after the grant
	task automatic read_word(input int core, input addr_t addr, output resp_t resp,
			output word_t data);
		int waited;
		waited = 0;
		@(posedge clk);
		if (core == 1) begin
			req_core1  <= 1'b1;
			addr_core1 <= addr;
		end else begin
			req_core2  <= 1'b1;
			addr_core2 <= addr;
		end
		@(negedge clk);
		while (!is_granted(core)) begin
			if (waited == grant_limit) begin
				abort_run($sformatf("core %0d was never granted a read", core));
			end else begin
				waited++;
				@(negedge clk);
			end
		end
		@(posedge clk);
		if (core == 1) begin
			req_core1 <= 1'b0;
		end else begin
			req_core2 <= 1'b0;
		end
		@(negedge clk);
		check_count++;
		if (!has_response(core)) begin
			error_count++;
			$display("core %0d got no response in the cycle after its grant", core);
		end
		resp = (core == 1) ? resp_core1 : resp_core2;
		data = (core == 1) ? data_core1 : data_core2;
	endtask

	// One-cycle flush pulse
	task automatic flush_word(input int core, input addr_t addr, input word_t data);
		@(posedge clk);
		if (core == 1) begin
			flush_core1      <= 1'b1;
			flush_addr_core1 <= addr;
			flush_data_core1 <= data;
		end else begin
			flush_core2      <= 1'b1;
			flush_addr_core2 <= addr;
			flush_data_core2 <= data;
		end
		@(posedge clk);
		flush_core1 <= 1'b0;
		flush_core2 <= 1'b0;
	endtask

	// Called in the cycle after a missed read and returns in the reply cycle
	task automatic wait_fill(input string name, input addr_t addr);
		int waited;
		waited = 0;
		check_count++;
		if (!dmem_read) begin
			error_count++;
			$display("%s: the missed read did not raise dmem_read", name);
		end
		check_value({name, " dmem_addr"}, addr, dmem_addr);
		while (!dmem_valid) begin
			if (waited == fill_limit) begin
				abort_run($sformatf("%s: data memory never replied", name));
			end else begin
				waited++;
				@(negedge clk);
			end
		end
	endtask

	`include "coherence_bus_tests.svh"

	initial begin
		reset            = 1'b1;
		req_core1        = 1'b0;
		addr_core1       = '0;
		snoop_hit_core1  = 1'b0;
		snoop_data_core1 = '0;
		flush_core1      = 1'b0;
		flush_addr_core1 = '0;
		flush_data_core1 = '0;
		req_core2        = 1'b0;
		addr_core2       = '0;
		snoop_hit_core2  = 1'b0;
		snoop_data_core2 = '0;
		flush_core2      = 1'b0;
		flush_addr_core2 = '0;
		flush_data_core2 = '0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		miss_then_fill();
		peer_forwarding();
		arbitration_alternates();
		flush_placement();
		lru_eviction();
		repeat (4) @(posedge clk);
		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+sim
src/coherence_pkg.sv
src/bus_arbiter.sv
src/l2_cache.sv
src/bus_response.sv
src/coherence_bus_top.sv
sim/coherence_bus_tb.sv

// ==== src/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter import coherence_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  req_core1,
	input  logic  req_core2,
	input  addr_t addr_core1,
	input  addr_t addr_core2,
	input  logic  flush_core1,
	input  logic  flush_core2,
	input  addr_t flush_addr_core1,
	input  addr_t flush_addr_core2,
	input  word_t flush_data_core1,
	input  word_t flush_data_core2,
	output logic  grant_core1,
	output logic  grant_core2,
	output logic  lookup_valid,
	output logic  lookup_core,
	output addr_t lookup_addr,
	output logic  wr_valid,
	output addr_t wr_addr,
	output word_t wr_data
);

	// Core that wins the next tie (0 names core 1)
	logic toggle;
	logic both_req;

	assign both_req = req_core1 && req_core2;

	// Lone request always wins and a tie goes to the toggle
	assign grant_core1 = req_core1 && (!req_core2 || !toggle);
	assign grant_core2 = req_core2 && (!req_core1 || toggle);

	// Flip after every tie
	always_ff @(posedge clk) begin
		if (reset) begin
			toggle <= 1'b0;
		end else if (both_req) begin
			toggle <= !toggle;
		end
	end

	// One lookup per granted cycle
	assign lookup_valid = grant_core1 || grant_core2;
	assign lookup_core  = grant_core2;
	assign lookup_addr  = grant_core2 ? addr_core2 : addr_core1;

	// Core 1 wins when both flush at once
	assign wr_valid = flush_core1 || flush_core2;
	assign wr_addr  = flush_core1 ? flush_addr_core1 : flush_addr_core2;
	assign wr_data  = flush_core1 ? flush_data_core1 : flush_data_core2;

	// Back-to-back ties hand the bus to the other core
	tie_alternates: assert property (@(posedge clk) disable iff (reset)
		both_req ##1 both_req |->
			grant_core1 == $past(grant_core2) && grant_core2 == $past(grant_core1));

endmodule

`default_nettype wire

// ==== src/bus_response.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_response import coherence_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  lookup_valid,
	input  logic  lookup_core,
	input  logic  snoop_hit_core1,
	input  logic  snoop_hit_core2,
	input  word_t snoop_data_core1,
	input  word_t snoop_data_core2,
	input  logic  l2_hit,
	input  word_t l2_data,
	output logic  resp_valid_core1,
	output logic  resp_valid_core2,
	output resp_t resp_core1,
	output resp_t resp_core2,
	output word_t data_core1,
	output word_t data_core2
);

	// Snoop answer of the core that was not granted
	logic  peer_hit;
	word_t peer_data;
	// Response before the output register
	resp_t next_resp;
	word_t next_data;
	logic  to_core1;
	logic  to_core2;

	assign peer_hit  = lookup_core ? snoop_hit_core1 : snoop_hit_core2;
	assign peer_data = lookup_core ? snoop_data_core1 : snoop_data_core2;

	// Peer L1 first, then L2, else retry
	always_comb begin
		if (peer_hit) begin
			next_resp = resp_peer;
			next_data = peer_data;
		end else if (l2_hit) begin
			next_resp = resp_l2;
			next_data = l2_data;
		end else begin
			next_resp = resp_none;
			next_data = '0;
		end
	end

	assign to_core1 = lookup_valid && !lookup_core;
	assign to_core2 = lookup_valid && lookup_core;

	always_ff @(posedge clk) begin
		if (reset) begin
			resp_valid_core1 <= 1'b0;
			resp_valid_core2 <= 1'b0;
		end else begin
			resp_valid_core1 <= to_core1;
			resp_valid_core2 <= to_core2;
		end
	end

	// Each core keeps its last response until the next grant
	always_ff @(posedge clk) begin
		if (to_core1) begin
			resp_core1 <= next_resp;
			data_core1 <= next_data;
		end
		if (to_core2) begin
			resp_core2 <= next_resp;
			data_core2 <= next_data;
		end
	end

	// Every delivered response carries a defined code
	resp_code_core1: assert property (@(posedge clk) disable iff (reset)
		resp_valid_core1 |-> resp_core1 != 2'b00);
	resp_code_core2: assert property (@(posedge clk) disable iff (reset)
		resp_valid_core2 |-> resp_core2 != 2'b00);

endmodule

`default_nettype wire

// ==== src/coherence_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module coherence_bus_top import coherence_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	// Core 1
	input  logic  req_core1,
	input  addr_t addr_core1,
	input  logic  snoop_hit_core1,
	input  word_t snoop_data_core1,
	input  logic  flush_core1,
	input  addr_t flush_addr_core1,
	input  word_t flush_data_core1,
	output logic  grant_core1,
	output logic  resp_valid_core1,
	output resp_t resp_core1,
	output word_t data_core1,
	// Core 2
	input  logic  req_core2,
	input  addr_t addr_core2,
	input  logic  snoop_hit_core2,
	input  word_t snoop_data_core2,
	input  logic  flush_core2,
	input  addr_t flush_addr_core2,
	input  word_t flush_data_core2,
	output logic  grant_core2,
	output logic  resp_valid_core2,
	output resp_t resp_core2,
	output word_t data_core2,
	// External data memory
	output logic  dmem_read,
	output addr_t dmem_addr,
	input  logic  dmem_valid,
	input  word_t dmem_data
);

	// Granted read
	logic  lookup_valid;
	logic  lookup_core;
	addr_t lookup_addr;
	// Selected flush
	logic  wr_valid;
	addr_t wr_addr;
	word_t wr_data;
	// L2 answer for the lookup
	logic  l2_hit;
	word_t l2_data;

	bus_arbiter u_arbiter (
		.clk              (clk),
		.reset            (reset),
		.req_core1        (req_core1),
		.req_core2        (req_core2),
		.addr_core1       (addr_core1),
		.addr_core2       (addr_core2),
		.flush_core1      (flush_core1),
		.flush_core2      (flush_core2),
		.flush_addr_core1 (flush_addr_core1),
		.flush_addr_core2 (flush_addr_core2),
		.flush_data_core1 (flush_data_core1),
		.flush_data_core2 (flush_data_core2),
		.grant_core1      (grant_core1),
		.grant_core2      (grant_core2),
		.lookup_valid     (lookup_valid),
		.lookup_core      (lookup_core),
		.lookup_addr      (lookup_addr),
		.wr_valid         (wr_valid),
		.wr_addr          (wr_addr),
		.wr_data          (wr_data)
	);

	l2_cache u_l2 (
		.clk          (clk),
		.reset        (reset),
		.lookup_valid (lookup_valid),
		.lookup_addr  (lookup_addr),
		.wr_valid     (wr_valid),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.l2_hit       (l2_hit),
		.l2_data      (l2_data),
		.dmem_read    (dmem_read),
		.dmem_addr    (dmem_addr),
		.dmem_valid   (dmem_valid),
		.dmem_data    (dmem_data)
	);

	bus_response u_response (
		.clk              (clk),
		.reset            (reset),
		.lookup_valid     (lookup_valid),
		.lookup_core      (lookup_core),
		.snoop_hit_core1  (snoop_hit_core1),
		.snoop_hit_core2  (snoop_hit_core2),
		.snoop_data_core1 (snoop_data_core1),
		.snoop_data_core2 (snoop_data_core2),
		.l2_hit           (l2_hit),
		.l2_data          (l2_data),
		.resp_valid_core1 (resp_valid_core1),
		.resp_valid_core2 (resp_valid_core2),
		.resp_core1       (resp_core1),
		.resp_core2       (resp_core2),
		.data_core1       (data_core1),
		.data_core2       (data_core2)
	);

endmodule

`default_nettype wire

// ==== src/coherence_pkg.sv ====
`default_nettype none

package coherence_pkg;

	// Byte address and data word widths
	localparam int addr_width   = 32;
	localparam int data_width   = 32;

	// Word address split for the L2
	localparam int offset_width = 2;
	localparam int index_width  = 9;
	localparam int tag_width    = 21;

	// Two ways of 512 sets each
	localparam int num_sets     = 512;

	// Lowest bit of the set index and of the tag in a byte address
	localparam int index_lsb    = offset_width;
	localparam int tag_lsb      = offset_width + index_width;

	typedef logic [addr_width-1:0]  addr_t;
	typedef logic [data_width-1:0]  word_t;
	typedef logic [index_width-1:0] index_t;
	typedef logic [tag_width-1:0]   tag_t;

	// Source of a read response
	typedef enum logic [1:0] {
		// Word forwarded from the other core's L1
		resp_peer = 2'b01,
		// Word read from the L2
		resp_l2   = 2'b10,
		// Nothing found, core retries later
		resp_none = 2'b11
	} resp_t;

	// L2 miss-fill FSM
	typedef enum logic [1:0] {
		// No fill in progress
		l2_idle  = 2'b00,
		// Waiting on data memory
		l2_fetch = 2'b01,
		// Fill word captured, waiting for a free write slot
		l2_write = 2'b10
	} l2_state_t;

endpackage

`default_nettype wire

// ==== src/l2_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_cache import coherence_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  lookup_valid,
	input  addr_t lookup_addr,
	input  logic  wr_valid,
	input  addr_t wr_addr,
	input  word_t wr_data,
	output logic  l2_hit,
	output word_t l2_data,
	output logic  dmem_read,
	output addr_t dmem_addr,
	input  logic  dmem_valid,
	input  word_t dmem_data
);

	// Tag and data arrays, one pair per way
	tag_t  tag_way0  [num_sets];
	tag_t  tag_way1  [num_sets];
	word_t data_way0 [num_sets];
	word_t data_way1 [num_sets];
	// Valid bits per way, and the least recently used way per set
	logic [num_sets-1:0] valid_way0;
	logic [num_sets-1:0] valid_way1;
	logic [num_sets-1:0] lru_way;

	// Fill FSM and its saved miss
	l2_state_t state;
	addr_t     miss_addr;
	word_t     fill_data;
	logic      miss_start;

	// Lookup side
	index_t lk_index;
	tag_t   lk_tag;
	logic   hit_way0;
	logic   hit_way1;
	logic   fill_bypass;

	// Flush side
	index_t wr_index;
	tag_t   wr_tag;
	logic   match_way0;
	logic   match_way1;
	logic   flush_way;

	// Fill side
	index_t fill_index;
	tag_t   fill_tag;
	logic   fill_way;
	logic   fill_write;

	// Single array write port
	logic   mem_we;
	logic   mem_way;
	index_t mem_index;
	tag_t   mem_tag;
	word_t  mem_data;

	assign lk_index = lookup_addr[tag_lsb-1:index_lsb];
	assign lk_tag   = lookup_addr[addr_width-1:tag_lsb];
	assign hit_way0 = valid_way0[lk_index] && (tag_way0[lk_index] == lk_tag);
	assign hit_way1 = valid_way1[lk_index] && (tag_way1[lk_index] == lk_tag);

	// Captured fill word answers before it reaches the arrays
	assign fill_bypass = (state == l2_write) &&
		(lookup_addr[addr_width-1:index_lsb] == miss_addr[addr_width-1:index_lsb]);

	assign l2_hit = hit_way0 || hit_way1 || fill_bypass;

	always_comb begin
		if (hit_way1) begin
			l2_data = data_way1[lk_index];
		end else if (hit_way0) begin
			l2_data = data_way0[lk_index];
		end else begin
			l2_data = fill_data;
		end
	end

	assign wr_index   = wr_addr[tag_lsb-1:index_lsb];
	assign wr_tag     = wr_addr[addr_width-1:tag_lsb];
	assign match_way0 = valid_way0[wr_index] && (tag_way0[wr_index] == wr_tag);
	assign match_way1 = valid_way1[wr_index] && (tag_way1[wr_index] == wr_tag);

	// Flush goes to the matching way, then a free way, then the LRU way
	always_comb begin
		if (match_way0) begin
			flush_way = 1'b0;
		end else if (match_way1) begin
			flush_way = 1'b1;
		end else if (!valid_way0[wr_index]) begin
			flush_way = 1'b0;
		end else if (!valid_way1[wr_index]) begin
			flush_way = 1'b1;
		end else begin
			flush_way = lru_way[wr_index];
		end
	end

	assign fill_index = miss_addr[tag_lsb-1:index_lsb];
	assign fill_tag   = miss_addr[addr_width-1:tag_lsb];

	// Fill takes a free way first, else the LRU way
	always_comb begin
		if (!valid_way0[fill_index]) begin
			fill_way = 1'b0;
		end else if (!valid_way1[fill_index]) begin
			fill_way = 1'b1;
		end else begin
			fill_way = lru_way[fill_index];
		end
	end

	// Flush owns the port, fill waits for a quiet cycle
	assign fill_write = (state == l2_write) && !wr_valid;
	assign mem_we     = wr_valid || fill_write;
	assign mem_way    = wr_valid ? flush_way : fill_way;
	assign mem_index  = wr_valid ? wr_index : fill_index;
	assign mem_tag    = wr_valid ? wr_tag : fill_tag;
	assign mem_data   = wr_valid ? wr_data : fill_data;

	always_ff @(posedge clk) begin
		if (mem_we) begin
			if (mem_way) begin
				tag_way1[mem_index]  <= mem_tag;
				data_way1[mem_index] <= mem_data;
			end else begin
				tag_way0[mem_index]  <= mem_tag;
				data_way0[mem_index] <= mem_data;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_way0 <= '0;
			valid_way1 <= '0;
			lru_way    <= '0;
		end else begin
			// Hit way becomes most recent
			if (lookup_valid && (hit_way0 || hit_way1)) begin
				lru_way[lk_index] <= !hit_way1;
			end
			// Written way becomes most recent, overrides a hit in the same set
			if (mem_we) begin
				if (mem_way) begin
					valid_way1[mem_index] <= 1'b1;
				end else begin
					valid_way0[mem_index] <= 1'b1;
				end
				lru_way[mem_index] <= !mem_way;
			end
		end
	end

	// Only an idle controller starts a fill
	assign miss_start = lookup_valid && !l2_hit && (state == l2_idle);

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= l2_idle;
			dmem_read <= 1'b0;
		end else begin
			case (state)
				l2_idle: begin
					if (miss_start) begin
						state     <= l2_fetch;
						dmem_read <= 1'b1;
					end
				end
				l2_fetch: begin
					if (dmem_valid) begin
						state     <= l2_write;
						dmem_read <= 1'b0;
					end
				end
				l2_write: begin
					if (!wr_valid) begin
						state <= l2_idle;
					end
				end
				default: begin
					state     <= l2_idle;
					dmem_read <= 1'b0;
				end
			endcase
		end
	end

	// Missed address and returned word
	always_ff @(posedge clk) begin
		if (miss_start) begin
			miss_addr <= lookup_addr;
		end
		if ((state == l2_fetch) && dmem_valid) begin
			fill_data <= dmem_data;
		end
	end

	assign dmem_addr = miss_addr;

	// Memory request register tracks the FSM
	read_in_fetch: assert property (@(posedge clk) disable iff (reset)
		dmem_read |-> state == l2_fetch);

	// Memory sees one address for the whole request
	read_addr_stable: assert property (@(posedge clk) disable iff (reset)
		dmem_read ##1 dmem_read |-> $stable(dmem_addr));

endmodule

`default_nettype wire
